/* tcb_subsystem.f */
src/tcb_pkg.sv
src/tcb_map_pkg.sv
src/tcb_register_backpressure.sv
src/tcb_mem.sv
src/tcb_fifo_port.sv
src/tcb_interconnect.sv
src/tcb_subsystem.sv
verif/tcb_checker.sv
verif/tcb_subsystem_tb.sv

/* Bender.yml */
package:
  name: tcb_subsystem

sources:
  - files:
      - src/tcb_pkg.sv
      - src/tcb_map_pkg.sv
      - src/tcb_register_backpressure.sv
      - src/tcb_mem.sv
      - src/tcb_fifo_port.sv
      - src/tcb_interconnect.sv
      - src/tcb_subsystem.sv
  - target: test
    files:
      - verif/tcb_checker.sv
      - verif/tcb_subsystem_tb.sv

/* verif/tcb_subsystem_tb.sv */
`timescale 1ns/1ps

module tcb_subsystem_tb;

  import tcb_pkg::*;

  localparam int unsigned MEM_WORDS  = 64;
  localparam int unsigned FIFO_DEPTH = 4;

  // table shorthands
  localparam logic RD    = 1'b0;
  localparam logic WR    = 1'b1;
  localparam logic GAP   = 1'b0;
  localparam logic TIGHT = 1'b1;
  localparam logic OK    = 1'b0;
  localparam logic BAD   = 1'b1;
  // any address with the top bit set
  localparam logic [ADR_W-1:0] FIFO_ADR = 16'h8000;

  // tight rows follow the previous one with no idle cycle
  typedef struct packed {
    logic             tight;
    logic             wen;
    logic [ADR_W-1:0] adr;
    siz_t             siz;
    logic [BEN_W-1:0] ben;
    logic [DAT_W-1:0] wdt;
    logic [DAT_W-1:0] exp_rdt;
    logic             exp_err;
  } row_t;

  logic             sub = 1'b0;
  logic             reset;
  logic             vld;
  logic             rdy;
  logic             wen;
  logic [ADR_W-1:0] adr;
  siz_t             siz;
  logic [BEN_W-1:0] ben;
  logic [DAT_W-1:0] wdt;
  logic [DAT_W-1:0] rdt;
  logic             err;
  logic             rsp_vld;

  row_t       rows [$];
  logic [7:0] lfsr   = 8'd28;
  int         cycles = 0;
  int         limit  = 0;
  int         gap;

  always #10 sub = ~sub;

  tcb_subsystem #(.MEM_WORDS (MEM_WORDS), .FIFO_DEPTH (FIFO_DEPTH)) tcb_subsystem_i (
    .sub, .reset, .vld, .rdy, .wen, .adr, .siz, .ben, .wdt, .rdt, .err, .rsp_vld
  );

  tcb_checker checker_i (.sub, .reset, .rdy, .rsp_vld, .rdt, .err);

  // galois form, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] state);
    return state[0] ? ((state >> 1) ^ 8'hB8) : (state >> 1);
  endfunction

  // 0 to 3 idle cycles, one step per bit
  task automatic take_gap(output int n);
    n = 0;
    repeat (2) begin
      n = (n << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic add_row(input logic tight, input logic w, input logic [ADR_W-1:0] a,
                         input siz_t s, input logic [BEN_W-1:0] b, input logic [DAT_W-1:0] d,
                         input logic [DAT_W-1:0] exp_rdt, input logic exp_err);
    rows.push_back('{tight, w, a, s, b, d, exp_rdt, exp_err});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    // fifo empty straight out of reset
    add_row(GAP, RD, FIFO_ADR, SIZ_WORD, 4'hF, 32'h0, 32'h0, BAD);
    // full words, then partial merges
    add_row(GAP, WR, 16'h0000, SIZ_WORD, 4'hF, 32'h1122_3344, 32'h0, OK);
    add_row(GAP, WR, 16'h0004, SIZ_WORD, 4'hF, 32'hAABB_CCDD, 32'h0, OK);
    add_row(GAP, WR, 16'h0000, SIZ_WORD, 4'h5, 32'h5566_7788, 32'h0, OK);
    add_row(GAP, WR, 16'h0004, SIZ_WORD, 4'h8, 32'hEE00_0000, 32'h0, OK);
    add_row(GAP, WR, 16'h0005, SIZ_BYTE, 4'h2, 32'h0000_FF00, 32'h0, OK);
    add_row(GAP, WR, 16'h0002, SIZ_HALF, 4'hC, 32'h9999_0000, 32'h0, OK);
    add_row(GAP, RD, 16'h0000, SIZ_WORD, 4'hF, 32'h0, 32'h9999_3388, OK);
    add_row(GAP, RD, 16'h0004, SIZ_WORD, 4'hF, 32'h0, 32'hEEBB_FFDD, OK);
    // misaligned, nothing written, reads zero
    add_row(GAP, WR, 16'h0001, SIZ_HALF, 4'h6, 32'hDEAD_BEEF, 32'h0, BAD);
    add_row(GAP, WR, 16'h0006, SIZ_WORD, 4'hF, 32'h1234_5678, 32'h0, BAD);
    add_row(GAP, RD, 16'h0002, SIZ_WORD, 4'hF, 32'h0, 32'h0, BAD);
    add_row(GAP, RD, 16'h0003, SIZ_HALF, 4'hF, 32'h0, 32'h0, BAD);
    add_row(GAP, RD, 16'h0000, SIZ_WORD, 4'hF, 32'h0, 32'h9999_3388, OK);
    add_row(GAP, RD, 16'h0004, SIZ_WORD, 4'hF, 32'h0, 32'hEEBB_FFDD, OK);
    // word 64 wraps onto word 0
    add_row(GAP, RD, 16'h0100, SIZ_WORD, 4'hF, 32'h0, 32'h9999_3388, OK);
    // fifo fill past depth, then drain past empty
    add_row(GAP, RD, FIFO_ADR, SIZ_WORD, 4'hF, 32'h0, 32'h0, BAD);
    add_row(GAP, WR, FIFO_ADR, SIZ_WORD, 4'hF, 32'hA000_0001, 32'h0, OK);
    add_row(GAP, WR, FIFO_ADR, SIZ_WORD, 4'hF, 32'hA000_0002, 32'h0, OK);
    add_row(GAP, WR, FIFO_ADR, SIZ_WORD, 4'hF, 32'hA000_0003, 32'h0, OK);
    add_row(GAP, WR, FIFO_ADR, SIZ_WORD, 4'hF, 32'hA000_0004, 32'h0, OK);
    add_row(GAP, WR, FIFO_ADR, SIZ_WORD, 4'hF, 32'hA000_0005, 32'h0, BAD);
    add_row(GAP, RD, FIFO_ADR, SIZ_WORD, 4'hF, 32'h0, 32'hA000_0001, OK);
    add_row(GAP, RD, FIFO_ADR, SIZ_WORD, 4'hF, 32'h0, 32'hA000_0002, OK);
    add_row(GAP, RD, FIFO_ADR, SIZ_WORD, 4'hF, 32'h0, 32'hA000_0003, OK);
    add_row(GAP, RD, FIFO_ADR, SIZ_WORD, 4'hF, 32'h0, 32'hA000_0004, OK);
    add_row(GAP, RD, FIFO_ADR, SIZ_WORD, 4'hF, 32'h0, 32'h0, BAD);
    // back to back, stalls through the slice
    add_row(GAP,   WR, FIFO_ADR, SIZ_WORD, 4'hF, 32'hB000_0001, 32'h0, OK);
    add_row(TIGHT, WR, FIFO_ADR, SIZ_WORD, 4'hF, 32'hB000_0002, 32'h0, OK);
    add_row(TIGHT, RD, 16'h0000, SIZ_WORD, 4'hF, 32'h0, 32'h9999_3388, OK);
    add_row(TIGHT, WR, 16'h0008, SIZ_WORD, 4'hF, 32'hCAFE_F00D, 32'h0, OK);
    add_row(TIGHT, RD, FIFO_ADR, SIZ_WORD, 4'hF, 32'h0, 32'hB000_0001, OK);
    add_row(TIGHT, RD, FIFO_ADR, SIZ_WORD, 4'hF, 32'h0, 32'hB000_0002, OK);
    add_row(TIGHT, RD, 16'h0008, SIZ_WORD, 4'hF, 32'h0, 32'hCAFE_F00D, OK);
    add_row(TIGHT, RD, FIFO_ADR, SIZ_WORD, 4'hF, 32'h0, 32'h0, BAD);
    add_row(TIGHT, RD, 16'h0004, SIZ_WORD, 4'hF, 32'h0, 32'hEEBB_FFDD, OK);
  endtask

  // present one row, hold it until accepted
  task automatic send_row(input row_t r);
    vld = 1'b1;
    wen = r.wen;
    adr = r.adr;
    siz = r.siz;
    ben = r.ben;
    wdt = r.wdt;
    @(negedge sub);
    while (!rdy) @(negedge sub);
    @(posedge sub);
    #1;
    checker_i.push_expected(r.exp_rdt, r.exp_err);
  endtask

  task automatic print_counts(input int timeouts);
    $display("errors: %0d mismatch, %0d other, %0d timeout",
             checker_i.mismatch_cnt, checker_i.other_cnt, timeouts);
  endtask

  // run limit from the table length
  always @(posedge sub) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("run stopped after %0d cycles, %0d responses outstanding",
               cycles, checker_i.pending());
      print_counts(1);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    vld   = 1'b0;
    wen   = 1'b0;
    adr   = '0;
    siz   = SIZ_BYTE;
    ben   = '0;
    wdt   = '0;
    build_table();
    limit = rows.size() * 8 + 20;
    repeat (4) @(posedge sub);
    #1;
    reset = 1'b0;
    foreach (rows[i]) begin
      if (!rows[i].tight) begin
        take_gap(gap);
        vld = 1'b0;
        repeat (gap) begin
          @(posedge sub);
          #1;
        end
      end
      send_row(rows[i]);
    end
    vld = 1'b0;
    // drain, then a few cycles to catch extra responses
    while (checker_i.pending() != 0) @(posedge sub);
    repeat (4) @(posedge sub);
    checker_i.final_check();
    print_counts(0);
    if (checker_i.mismatch_cnt + checker_i.other_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : tcb_subsystem_tb

/* verif/tcb_checker.sv */
`timescale 1ns/1ps

module tcb_checker (
  input  logic                      sub,
  input  logic                      reset,
  input  logic                      rdy,
  input  logic                      rsp_vld,
  input  logic [tcb_pkg::DAT_W-1:0] rdt,
  input  logic                      err
);

  import tcb_pkg::*;

  // expected responses, oldest first
  logic [DAT_W-1:0] exp_rdt_q [$];
  logic             exp_err_q [$];

  int   mismatch_cnt = 0;
  int   other_cnt    = 0;
  logic was_reset    = 1'b1;

  // called by the manager on each accepted request
  task automatic push_expected(input logic [DAT_W-1:0] exp_rdt, input logic exp_err);
    exp_rdt_q.push_back(exp_rdt);
    exp_err_q.push_back(exp_err);
  endtask

  function automatic int pending();
    return exp_rdt_q.size();
  endfunction

  // leftovers mean lost responses
  task automatic final_check();
    if (exp_rdt_q.size() != 0) begin
      other_cnt++;
      $display("%0d expected responses never arrived", exp_rdt_q.size());
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // response compare, sampled mid cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge sub) begin
    logic [DAT_W-1:0] want_rdt;
    logic             want_err;
    // first cycle out of reset
    if (was_reset && !reset) begin
      if (rdy !== 1'b1) begin
        other_cnt++;
        $display("rdy was low in the first cycle after reset at %0t", $time);
      end
      if (rsp_vld !== 1'b0) begin
        other_cnt++;
        $display("rsp_vld was high in the first cycle after reset at %0t", $time);
      end
    end
    was_reset = reset;
    if (!reset && rsp_vld) begin
      if (exp_rdt_q.size() == 0) begin
        // duplicate or spurious
        other_cnt++;
        $display("response at %0t with no request outstanding", $time);
      end else begin
        want_rdt = exp_rdt_q.pop_front();
        want_err = exp_err_q.pop_front();
        if (rdt !== want_rdt) begin
          mismatch_cnt++;
          $display("Mismatch at %0t: rdt expected %08h, got %08h", $time, want_rdt, rdt);
        end
        if (err !== want_err) begin
          mismatch_cnt++;
          $display("Mismatch at %0t: err expected %b, got %b", $time, want_err, err);
        end
      end
    end
  end

endmodule : tcb_checker

/* src/tcb_subsystem.sv */
`timescale 1ns/1ps

module tcb_subsystem #(
  parameter int unsigned MEM_WORDS  = 64,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                      sub,
  input  logic                      reset,
  // request from the manager
  input  logic                      vld,
  output logic                      rdy,
  input  logic                      wen,
  input  logic [tcb_pkg::ADR_W-1:0] adr,
  input  tcb_pkg::siz_t             siz,
  input  logic [tcb_pkg::BEN_W-1:0] ben,
  input  logic [tcb_pkg::DAT_W-1:0] wdt,
  // response
  output logic [tcb_pkg::DAT_W-1:0] rdt,
  output logic                      err,
  output logic                      rsp_vld
);

  import tcb_pkg::*;

  // slice to interconnect and subordinates
  logic             man_vld;
  logic             man_rdy;
  logic             man_wen;
  logic [ADR_W-1:0] man_adr;
  siz_t             man_siz;
  logic [BEN_W-1:0] man_ben;
  logic [DAT_W-1:0] man_wdt;

  // memory side
  logic             mem_vld;
  logic             mem_rdy;
  logic [DAT_W-1:0] mem_rdt;
  logic             mem_err;

  // fifo side
  logic             fifo_vld;
  logic             fifo_rdy;
  logic [DAT_W-1:0] fifo_rdt;
  logic             fifo_err;

  tcb_register_backpressure slice_i (
    .sub, .reset,
    .sub_vld (vld), .sub_rdy (rdy), .sub_wen (wen), .sub_adr (adr),
    .sub_siz (siz), .sub_ben (ben), .sub_wdt (wdt),
    .man_vld, .man_rdy, .man_wen, .man_adr, .man_siz, .man_ben, .man_wdt
  );

  tcb_interconnect interconnect_i (
    .sub, .reset,
    .vld (man_vld), .adr (man_adr), .rdy (man_rdy),
    .mem_vld, .mem_rdy, .mem_rdt, .mem_err,
    .fifo_vld, .fifo_rdy, .fifo_rdt, .fifo_err,
    .rdt, .err, .rsp_vld
  );

  // request fields shared by both subordinates
  tcb_mem #(.MEM_WORDS (MEM_WORDS)) mem_i (
    .sub, .reset,
    .vld (mem_vld), .rdy (mem_rdy), .wen (man_wen), .adr (man_adr),
    .siz (man_siz), .ben (man_ben), .wdt (man_wdt), .rdt (mem_rdt), .err (mem_err)
  );

  tcb_fifo_port #(.FIFO_DEPTH (FIFO_DEPTH)) fifo_i (
    .sub, .reset,
    .vld (fifo_vld), .rdy (fifo_rdy), .wen (man_wen), .wdt (man_wdt),
    .rdt (fifo_rdt), .err (fifo_err)
  );

endmodule : tcb_subsystem

/* src/tcb_interconnect.sv */
`timescale 1ns/1ps

module tcb_interconnect (
  input  logic                      sub,
  input  logic                      reset,
  // upstream request
  input  logic                      vld,
  input  logic [tcb_pkg::ADR_W-1:0] adr,
  output logic                      rdy,
  // memory subordinate
  output logic                      mem_vld,
  input  logic                      mem_rdy,
  input  logic [tcb_pkg::DAT_W-1:0] mem_rdt,
  input  logic                      mem_err,
  // fifo subordinate
  output logic                      fifo_vld,
  input  logic                      fifo_rdy,
  input  logic [tcb_pkg::DAT_W-1:0] fifo_rdt,
  input  logic                      fifo_err,
  // combined response
  output logic [tcb_pkg::DAT_W-1:0] rdt,
  output logic                      err,
  output logic                      rsp_vld
);

  import tcb_map_pkg::*;

  region_t sel;
  region_t rsp_sel;
  logic    trn;

  ////////////////////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////////////////////

  assign sel = region_t'(adr[REGION_BIT]);

  // valid only toward the addressed one
  assign mem_vld  = vld & (sel == REGION_MEM);
  assign fifo_vld = vld & (sel == REGION_FIFO);

  // ready from the addressed one
  assign rdy = (sel == REGION_FIFO) ? fifo_rdy : mem_rdy;
  assign trn = vld & rdy;

  ////////////////////////////////////////////////////////////////////////////
  // response combine
  ////////////////////////////////////////////////////////////////////////////

  // remember where the last transfer went
  always_ff @(posedge sub) begin
    if (reset) begin
      rsp_sel <= REGION_MEM;
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= trn;
      if (trn) begin
        rsp_sel <= sel;
      end
    end
  end

  // subordinates hold their outputs until the next transfer
  assign rdt = (rsp_sel == REGION_FIFO) ? fifo_rdt : mem_rdt;
  assign err = (rsp_sel == REGION_FIFO) ? fifo_err : mem_err;

  // at most one subordinate addressed
  assert property (@(posedge sub) disable iff (reset) !(mem_vld && fifo_vld));

endmodule : tcb_interconnect

/* src/tcb_fifo_port.sv */
`timescale 1ns/1ps

module tcb_fifo_port #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                      sub,
  input  logic                      reset,
  input  logic                      vld,
  output logic                      rdy,
  input  logic                      wen,
  input  logic [tcb_pkg::DAT_W-1:0] wdt,
  output logic [tcb_pkg::DAT_W-1:0] rdt,
  output logic                      err
);

  import tcb_pkg::*;
  import tcb_map_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  // pointers wrap by overflow
  if (FIFO_DEPTH != 2**PTR_W) begin : g_depth_check
    $error("FIFO_DEPTH = %0d is not a power of two", FIFO_DEPTH);
  end

  logic [DAT_W-1:0] fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   cnt;
  fifo_state_t      state;
  logic             trn;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  ////////////////////////////////////////////////////////////////////////////
  // access timing
  ////////////////////////////////////////////////////////////////////////////

  assign rdy = (state == FIFO_IDLE);
  assign trn = vld & rdy;

  // one busy cycle after every access
  always_ff @(posedge sub) begin
    if (reset) begin
      state <= FIFO_IDLE;
    end else begin
      case (state)
        FIFO_IDLE: state <= trn ? FIFO_BUSY : FIFO_IDLE;
        FIFO_BUSY: state <= FIFO_IDLE;
        default:   state <= FIFO_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  assign full  = (cnt == (PTR_W+1)'(FIFO_DEPTH));
  assign empty = (cnt == '0);
  // overflow and underflow are dropped
  assign push  = trn &  wen & ~full;
  assign pop   = trn & ~wen & ~empty;

  always_ff @(posedge sub) begin
    if (push) begin
      fifo_mem[wr_ptr] <= wdt;
    end
  end

  always_ff @(posedge sub) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + PTR_W'(1);
      cnt    <= cnt + (PTR_W+1)'(1);
    end else if (pop) begin
      rd_ptr <= rd_ptr + PTR_W'(1);
      cnt    <= cnt - (PTR_W+1)'(1);
    end
  end

  // zero unless popping
  always_ff @(posedge sub) begin
    if (trn) begin
      rdt <= pop ? fifo_mem[rd_ptr] : '0;
    end
  end

  always_ff @(posedge sub) begin
    if (reset) begin
      err <= 1'b0;
    end else if (trn) begin
      err <= wen ? full : empty;
    end
  end

  assert property (@(posedge sub) disable iff (reset) cnt <= FIFO_DEPTH);

endmodule : tcb_fifo_port

/* src/tcb_mem.sv */
`timescale 1ns/1ps

module tcb_mem #(
  parameter int unsigned MEM_WORDS = 64
) (
  input  logic                      sub,
  input  logic                      reset,
  input  logic                      vld,
  output logic                      rdy,
  input  logic                      wen,
  input  logic [tcb_pkg::ADR_W-1:0] adr,
  input  tcb_pkg::siz_t             siz,
  input  logic [tcb_pkg::BEN_W-1:0] ben,
  input  logic [tcb_pkg::DAT_W-1:0] wdt,
  output logic [tcb_pkg::DAT_W-1:0] rdt,
  output logic                      err
);

  import tcb_pkg::*;

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  logic [DAT_W-1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             mis;
  logic             trn;

  // never stalls
  assign rdy = 1'b1;
  assign trn = vld & rdy;

  // word address, wraps at the memory depth
  assign idx = IDX_W'(adr[ADR_W-1:2] % MEM_WORDS);

  // alignment by transfer size
  always_comb begin
    case (siz)
      SIZ_BYTE: mis = 1'b0;
      SIZ_HALF: mis = adr[0];
      SIZ_WORD: mis = |adr[1:0];
      // wider than the bus
      default:  mis = 1'b1;
    endcase
  end

  // aligned writes, enabled bytes only
  always_ff @(posedge sub) begin
    for (int unsigned b = 0; b < BEN_W; b++) begin
      if (trn & wen & ~mis & ben[b]) begin
        mem[idx][8*b +: 8] <= wdt[8*b +: 8];
      end
    end
  end

  // read data, zero for writes and misaligned access
  always_ff @(posedge sub) begin
    if (trn) begin
      rdt <= (wen | mis) ? '0 : mem[idx];
    end
  end

  always_ff @(posedge sub) begin
    if (reset) begin
      err <= 1'b0;
    end else if (trn) begin
      err <= mis;
    end
  end

endmodule : tcb_mem

/* src/tcb_register_backpressure.sv */
`timescale 1ns/1ps

module tcb_register_backpressure (
  input  logic                      sub,
  input  logic                      reset,
  // upstream, manager connects here
  input  logic                      sub_vld,
  output logic                      sub_rdy,
  input  logic                      sub_wen,
  input  logic [tcb_pkg::ADR_W-1:0] sub_adr,
  input  tcb_pkg::siz_t             sub_siz,
  input  logic [tcb_pkg::BEN_W-1:0] sub_ben,
  input  logic [tcb_pkg::DAT_W-1:0] sub_wdt,
  // downstream, toward the interconnect
  output logic                      man_vld,
  input  logic                      man_rdy,
  output logic                      man_wen,
  output logic [tcb_pkg::ADR_W-1:0] man_adr,
  output tcb_pkg::siz_t             man_siz,
  output logic [tcb_pkg::BEN_W-1:0] man_ben,
  output logic [tcb_pkg::DAT_W-1:0] man_wdt
);

  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // held request
  ////////////////////////////////////////////////////////////////////////////

  logic             tmp_wen;
  logic [ADR_W-1:0] tmp_adr;
  siz_t             tmp_siz;
  logic [BEN_W-1:0] tmp_ben;
  logic [DAT_W-1:0] tmp_wdt;

  // capture when accepted upstream but downstream stalls
  always_ff @(posedge sub) begin
    if (sub_vld & sub_rdy & ~man_rdy) begin
      tmp_wen <= sub_wen;
      tmp_adr <= sub_adr;
      tmp_siz <= sub_siz;
      tmp_ben <= sub_ben;
      // only enabled write bytes
      for (int unsigned b = 0; b < BEN_W; b++) begin
        if (sub_wen & sub_ben[b]) begin
          tmp_wdt[8*b +: 8] <= sub_wdt[8*b +: 8];
        end
      end
    end
  end

  // live request while ready, held one otherwise
  assign man_vld = sub_rdy ? sub_vld : 1'b1;
  assign man_wen = sub_rdy ? sub_wen : tmp_wen;
  assign man_adr = sub_rdy ? sub_adr : tmp_adr;
  assign man_siz = sub_rdy ? sub_siz : tmp_siz;
  assign man_ben = sub_rdy ? sub_ben : tmp_ben;
  assign man_wdt = sub_rdy ? sub_wdt : tmp_wdt;

  ////////////////////////////////////////////////////////////////////////////
  // upstream ready register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sub) begin
    if (reset) begin
      sub_rdy <= 1'b1;
    end else if (sub_rdy) begin
      // drop after a stalled acceptance
      sub_rdy <= ~(sub_vld & ~man_rdy);
    end else begin
      // back up once the held request leaves
      sub_rdy <= man_rdy;
    end
  end

  // a held request is always offered downstream
  assert property (@(posedge sub) disable iff (reset) !sub_rdy |-> man_vld);

  // held fields do not move until taken
  assert property (@(posedge sub) disable iff (reset)
    !sub_rdy && !man_rdy |=> $stable({man_wen, man_adr, man_siz, man_ben, man_wdt}));

endmodule : tcb_register_backpressure

/* src/tcb_map_pkg.sv */
package tcb_map_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////////////////////

  // top address bit picks the subordinate
  localparam int unsigned REGION_BIT = tcb_pkg::ADR_W - 1;

  // lower half memory, upper half fifo
  typedef enum logic {
    REGION_MEM  = 1'b0,
    REGION_FIFO = 1'b1
  } region_t;

  ////////////////////////////////////////////////////////////////////////////
  // fifo port states
  ////////////////////////////////////////////////////////////////////////////

  // busy lasts exactly one cycle after each access
  typedef enum logic {
    FIFO_IDLE = 1'b0,
    FIFO_BUSY = 1'b1
  } fifo_state_t;

endpackage : tcb_map_pkg

/* src/tcb_pkg.sv */
package tcb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////////////////////

  // byte address
  localparam int unsigned ADR_W = 16;
  // data bus
  localparam int unsigned DAT_W = 32;
  // one enable per data byte
  localparam int unsigned BEN_W = DAT_W / 8;

  // cycles from transfer to response, fixed in this subsystem
  localparam int unsigned DLY = 1;

  ////////////////////////////////////////////////////////////////////////////
  // transfer size
  ////////////////////////////////////////////////////////////////////////////

  // logarithmic size, bytes = 2**siz
  typedef enum logic [1:0] {
    SIZ_BYTE = 2'd0,
    SIZ_HALF = 2'd1,
    SIZ_WORD = 2'd2
  } siz_t;

endpackage : tcb_pkg
